// File: rtl/cache_cfg_pkg.sv
// Cache address and data word geometry
// Shared by the RTL blocks and the testbench

package cache_cfg_pkg;

    // Byte address width
    localparam int ADDR_WIDTH = 32;

    // Byte offset inside a cache line (16-byte lines)
    localparam int OFFSET_WIDTH = 4;

    // Request and store data width
    localparam int WORD_WIDTH = 32;

    // Byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One data word
    typedef logic [WORD_WIDTH-1:0] word_t;

endpackage

// File: rtl/cmo_pkg.sv
// Cache management operation encoding
// Handler FSM states

package cmo_pkg;

    // Operation carried on the request port
    typedef enum logic [1:0] {
        CMO_FENCE       = 2'd0,
        CMO_INVAL_NLINE = 2'd1,
        CMO_INVAL_SET   = 2'd2,
        CMO_INVAL_ALL   = 2'd3
    } cmo_op_e;

    // Handler FSM
    typedef enum logic [2:0] {
        CMOH_IDLE,
        CMOH_FENCE_WAIT,
        CMOH_INVAL_WAIT,
        CMOH_INVAL_CHECK,
        CMOH_INVAL_SET
    } cmo_state_e;

endpackage

// File: rtl/cache_dir.sv
// Tag and valid directory of the data cache
// Fill, combinational lookup, registered check and masked invalidate

`timescale 1ns/1ns

module cache_dir
    import cache_cfg_pkg::*;
#(
    parameter int NUM_SETS = 8,
    parameter int NUM_WAYS = 4
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         fill_valid_i,
    input  addr_t                                        fill_addr_i,
    input  logic [$clog2(NUM_WAYS)-1:0]                  fill_way_i,
    input  addr_t                                        lookup_addr_i,
    output logic                                         lookup_hit_o,
    input  logic                                         check_i,
    input  logic [$clog2(NUM_SETS)-1:0]                  check_set_i,
    input  logic [ADDR_WIDTH-OFFSET_WIDTH-$clog2(NUM_SETS)-1:0] check_tag_i,
    output logic [NUM_WAYS-1:0]                          check_hit_way_o,
    input  logic                                         inval_i,
    input  logic [$clog2(NUM_SETS)-1:0]                  inval_set_i,
    input  logic [NUM_WAYS-1:0]                          inval_way_i
);

    localparam int SET_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - SET_WIDTH;

    logic [TAG_WIDTH-1:0] tag_q [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]  valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0]  valid_d [NUM_SETS];

    logic [SET_WIDTH-1:0] fill_set;
    logic [TAG_WIDTH-1:0] fill_tag;
    logic [SET_WIDTH-1:0] lookup_set;
    logic [TAG_WIDTH-1:0] lookup_tag;
    logic [NUM_WAYS-1:0]  lookup_match;
    logic [NUM_WAYS-1:0]  check_match;
    logic [NUM_WAYS-1:0]  check_hit_way_q;

    assign fill_set   = fill_addr_i[OFFSET_WIDTH +: SET_WIDTH];
    assign fill_tag   = fill_addr_i[OFFSET_WIDTH+SET_WIDTH +: TAG_WIDTH];
    assign lookup_set = lookup_addr_i[OFFSET_WIDTH +: SET_WIDTH];
    assign lookup_tag = lookup_addr_i[OFFSET_WIDTH+SET_WIDTH +: TAG_WIDTH];

    // Per-way tag compare for the lookup and the check port
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookup_match[w] = valid_q[lookup_set][w] && (tag_q[lookup_set][w] == lookup_tag);
            check_match[w]  = valid_q[check_set_i][w] && (tag_q[check_set_i][w] == check_tag_i);
        end
    end

    assign lookup_hit_o    = |lookup_match;
    assign check_hit_way_o = check_hit_way_q;

    // Invalidate applied after the fill, so it wins on the same entry
    always_comb begin
        valid_d = valid_q;
        if (fill_valid_i) begin
            valid_d[fill_set][fill_way_i] = 1'b1;
        end
        if (inval_i) begin
            valid_d[inval_set_i] = valid_d[inval_set_i] & ~inval_way_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            valid_q <= valid_d;
        end
    end

    // Tag array and check result
    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            tag_q[fill_set][fill_way_i] <= fill_tag;
        end
        if (check_i) begin
            check_hit_way_q <= check_match;
        end
    end

endmodule

// File: rtl/write_buffer.sv
// Posted store buffer, circular FIFO
// Drains one entry per cycle on flush or on a store while full

`timescale 1ns/1ns

module write_buffer
    import cache_cfg_pkg::*;
#(
    parameter int WBUF_DEPTH = 4
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  st_valid_i,
    input  addr_t st_addr_i,
    input  word_t st_data_i,
    input  logic  flush_i,
    output logic  empty_o,
    output logic  mem_wr_o,
    output addr_t mem_addr_o,
    output word_t mem_data_o
);

    localparam int PTR_WIDTH = (WBUF_DEPTH > 1) ? $clog2(WBUF_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(WBUF_DEPTH + 1);

    addr_t addr_q [WBUF_DEPTH];
    word_t data_q [WBUF_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [CNT_WIDTH-1:0] count_q;

    logic full;
    logic push;
    logic pop;

    assign full    = (count_q == CNT_WIDTH'(WBUF_DEPTH));
    assign empty_o = (count_q == '0);

    // A store into a full buffer pushes the head out in the same cycle
    assign push = st_valid_i;
    assign pop  = !empty_o && (flush_i || (st_valid_i && full));

    assign mem_wr_o   = pop;
    assign mem_addr_o = addr_q[rd_ptr_q];
    assign mem_data_o = data_q[rd_ptr_q];

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(WBUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[wr_ptr_q] <= st_addr_i;
            data_q[wr_ptr_q] <= st_data_i;
        end
    end

endmodule

// File: rtl/cmo_handler.sv
// Cache management operation handler
// Sequences fences and line, set and full invalidations

`timescale 1ns/1ns

module cmo_handler
    import cache_cfg_pkg::*;
    import cmo_pkg::*;
#(
    parameter int NUM_SETS = 8,
    parameter int NUM_WAYS = 4
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         req_valid_i,
    output logic                                         req_ready_o,
    input  cmo_op_e                                      req_op_i,
    input  addr_t                                        req_addr_i,
    input  word_t                                        req_wdata_i,
    input  logic                                         wbuf_empty_i,
    input  logic                                         mshr_empty_i,
    input  logic                                         rtab_empty_i,
    output logic                                         wbuf_flush_o,
    output logic                                         dir_check_o,
    output logic [$clog2(NUM_SETS)-1:0]                  dir_check_set_o,
    output logic [ADDR_WIDTH-OFFSET_WIDTH-$clog2(NUM_SETS)-1:0] dir_check_tag_o,
    input  logic [NUM_WAYS-1:0]                          dir_hit_way_i,
    output logic                                         dir_inval_o,
    output logic [$clog2(NUM_SETS)-1:0]                  dir_inval_set_o,
    output logic [NUM_WAYS-1:0]                          dir_inval_way_o
);

    localparam int SET_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - SET_WIDTH;

    cmo_state_e           state_q, state_d;
    cmo_op_e              op_q, op_d;
    addr_t                addr_q, addr_d;
    logic [NUM_WAYS-1:0]  way_q, way_d;
    logic [SET_WIDTH-1:0] set_cnt_q, set_cnt_d;
    logic [SET_WIDTH-1:0] line_set;
    logic [TAG_WIDTH-1:0] line_tag;
    logic                 units_idle;

    // Line address split into set index and tag
    assign line_set = addr_q[OFFSET_WIDTH +: SET_WIDTH];
    assign line_tag = addr_q[OFFSET_WIDTH+SET_WIDTH +: TAG_WIDTH];

    assign dir_check_set_o = line_set;
    assign dir_check_tag_o = line_tag;

    assign units_idle  = mshr_empty_i && rtab_empty_i;
    assign req_ready_o = (state_q == CMOH_IDLE);

    always_comb begin
        state_d   = state_q;
        op_d      = op_q;
        addr_d    = addr_q;
        way_d     = way_q;
        set_cnt_d = set_cnt_q;

        wbuf_flush_o    = 1'b0;
        dir_check_o     = 1'b0;
        dir_inval_o     = 1'b0;
        dir_inval_set_o = line_set;
        dir_inval_way_o = '0;

        case (state_q)
            CMOH_IDLE: begin
                if (req_valid_i) begin
                    if (req_op_i == CMO_FENCE) begin
                        // Drain only once the replay table is empty
                        wbuf_flush_o = rtab_empty_i;
                        if (!rtab_empty_i || !wbuf_empty_i) begin
                            state_d = CMOH_FENCE_WAIT;
                        end
                    end else begin
                        op_d      = req_op_i;
                        addr_d    = req_addr_i;
                        way_d     = req_wdata_i[NUM_WAYS-1:0];
                        set_cnt_d = '0;
                        if (!units_idle) begin
                            state_d = CMOH_INVAL_WAIT;
                        end else if (req_op_i == CMO_INVAL_NLINE) begin
                            state_d = CMOH_INVAL_CHECK;
                        end else begin
                            state_d = CMOH_INVAL_SET;
                        end
                    end
                end
            end
            CMOH_FENCE_WAIT: begin
                wbuf_flush_o = rtab_empty_i;
                if (wbuf_empty_i && rtab_empty_i) begin
                    state_d = CMOH_IDLE;
                end
            end
            CMOH_INVAL_WAIT: begin
                if (units_idle) begin
                    state_d = (op_q == CMO_INVAL_NLINE) ? CMOH_INVAL_CHECK : CMOH_INVAL_SET;
                end
            end
            CMOH_INVAL_CHECK: begin
                dir_check_o = 1'b1;
                state_d     = CMOH_INVAL_SET;
            end
            CMOH_INVAL_SET: begin
                case (op_q)
                    CMO_INVAL_NLINE: begin
                        // Strobe only when some way hit
                        dir_inval_o     = |dir_hit_way_i;
                        dir_inval_way_o = dir_hit_way_i;
                        state_d         = CMOH_IDLE;
                    end
                    CMO_INVAL_ALL: begin
                        dir_inval_o     = 1'b1;
                        dir_inval_set_o = set_cnt_q;
                        dir_inval_way_o = '1;
                        set_cnt_d       = set_cnt_q + 1'b1;
                        if (set_cnt_q == SET_WIDTH'(NUM_SETS - 1)) begin
                            state_d = CMOH_IDLE;
                        end
                    end
                    default: begin
                        dir_inval_o     = 1'b1;
                        dir_inval_way_o = way_q;
                        state_d         = CMOH_IDLE;
                    end
                endcase
            end
            default: begin
                state_d = CMOH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= CMOH_IDLE;
            set_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            set_cnt_q <= set_cnt_d;
        end
    end

    // Latched request fields
    always_ff @(posedge clk_i) begin
        op_q   <= op_d;
        addr_q <= addr_d;
        way_q  <= way_d;
    end

endmodule

// File: rtl/cmo_subsys_top.sv
// Cache management subsystem top level
// Directory and write buffer side by side, driven by the CMO handler

`timescale 1ns/1ns

module cmo_subsys_top
    import cache_cfg_pkg::*;
    import cmo_pkg::*;
#(
    parameter int NUM_SETS   = 8,
    parameter int NUM_WAYS   = 4,
    parameter int WBUF_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  cmo_op_e                     req_op_i,
    input  addr_t                       req_addr_i,
    input  word_t                       req_wdata_i,
    input  logic                        fill_valid_i,
    input  addr_t                       fill_addr_i,
    input  logic [$clog2(NUM_WAYS)-1:0] fill_way_i,
    input  logic                        st_valid_i,
    input  addr_t                       st_addr_i,
    input  word_t                       st_data_i,
    output logic                        mem_wr_o,
    output addr_t                       mem_addr_o,
    output word_t                       mem_data_o,
    input  addr_t                       lookup_addr_i,
    output logic                        lookup_hit_o,
    input  logic                        mshr_empty_i,
    input  logic                        rtab_empty_i
);

    localparam int SET_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = ADDR_WIDTH - OFFSET_WIDTH - SET_WIDTH;

    logic                 dir_check;
    logic [SET_WIDTH-1:0] dir_check_set;
    logic [TAG_WIDTH-1:0] dir_check_tag;
    logic [NUM_WAYS-1:0]  dir_hit_way;
    logic                 dir_inval;
    logic [SET_WIDTH-1:0] dir_inval_set;
    logic [NUM_WAYS-1:0]  dir_inval_way;
    logic                 wbuf_flush;
    logic                 wbuf_empty;

    cache_dir #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) i_dir (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .fill_valid_i    (fill_valid_i),
        .fill_addr_i     (fill_addr_i),
        .fill_way_i      (fill_way_i),
        .lookup_addr_i   (lookup_addr_i),
        .lookup_hit_o    (lookup_hit_o),
        .check_i         (dir_check),
        .check_set_i     (dir_check_set),
        .check_tag_i     (dir_check_tag),
        .check_hit_way_o (dir_hit_way),
        .inval_i         (dir_inval),
        .inval_set_i     (dir_inval_set),
        .inval_way_i     (dir_inval_way)
    );

    write_buffer #(
        .WBUF_DEPTH (WBUF_DEPTH)
    ) i_wbuf (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .st_valid_i (st_valid_i),
        .st_addr_i  (st_addr_i),
        .st_data_i  (st_data_i),
        .flush_i    (wbuf_flush),
        .empty_o    (wbuf_empty),
        .mem_wr_o   (mem_wr_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o)
    );

    cmo_handler #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) i_cmoh (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .wbuf_empty_i    (wbuf_empty),
        .mshr_empty_i    (mshr_empty_i),
        .rtab_empty_i    (rtab_empty_i),
        .wbuf_flush_o    (wbuf_flush),
        .dir_check_o     (dir_check),
        .dir_check_set_o (dir_check_set),
        .dir_check_tag_o (dir_check_tag),
        .dir_hit_way_i   (dir_hit_way),
        .dir_inval_o     (dir_inval),
        .dir_inval_set_o (dir_inval_set),
        .dir_inval_way_o (dir_inval_way)
    );

endmodule

// File: bench/cmo_subsys_chk.sv
// Concurrent protocol assertions for the cache management subsystem
// Bound into cmo_subsys_top by the testbench

`timescale 1ns/1ns

module cmo_subsys_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic req_valid_i,
    input logic req_ready_i,
    input logic mem_wr_i,
    input logic dir_inval_i
);

    // Assertion failures seen so far
    int unsigned fail_cnt = 0;

    // Requester raises valid only while the handler is idle
    valid_needs_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> req_ready_i
    ) else begin
        fail_cnt++;
        $error("request valid high while ready is low");
    end

    mem_wr_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !$isunknown(mem_wr_i)
    ) else begin
        fail_cnt++;
        $error("memory write strobe is unknown");
    end

    // Invalidations only happen inside a busy sequence
    inval_not_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) dir_inval_i |-> !req_ready_i
    ) else begin
        fail_cnt++;
        $error("directory invalidate while the handler is idle");
    end

endmodule

// File: bench/tb_cmo_subsys.sv
// Testbench for the cache management subsystem
// Directed test tasks, reference model, memory write monitor, watchdog

`timescale 1ns/1ns

module tb_cmo_subsys
    import cache_cfg_pkg::*;
    import cmo_pkg::*;
();

    localparam int NUM_SETS      = 8;
    localparam int NUM_WAYS      = 4;
    localparam int WBUF_DEPTH    = 4;
    localparam int SET_WIDTH     = $clog2(NUM_SETS);
    localparam int WAY_WIDTH     = $clog2(NUM_WAYS);
    localparam int TAG_WIDTH     = ADDR_WIDTH - OFFSET_WIDTH - SET_WIDTH;
    localparam int READY_TIMEOUT = 100;
    // Several times the length of all directed tests
    localparam int WATCHDOG_NS   = 20000;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 req_valid;
    logic                 req_ready;
    cmo_op_e              req_op;
    addr_t                req_addr;
    word_t                req_wdata;
    logic                 fill_valid;
    addr_t                fill_addr;
    logic [WAY_WIDTH-1:0] fill_way;
    logic                 st_valid;
    addr_t                st_addr;
    word_t                st_data;
    logic                 mem_wr;
    addr_t                mem_addr;
    word_t                mem_data;
    addr_t                lookup_addr;
    logic                 lookup_hit;
    logic                 mshr_empty;
    logic                 rtab_empty;

    // Reference directory and expected memory writes
    logic                 ref_valid [NUM_SETS][NUM_WAYS];
    logic [TAG_WIDTH-1:0] ref_tag [NUM_SETS][NUM_WAYS];
    addr_t                exp_addr_q [$];
    word_t                exp_data_q [$];

    int errors;
    int checks;
    int mem_cnt;

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    cmo_subsys_top #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .WBUF_DEPTH (WBUF_DEPTH)
    ) i_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .req_op_i      (req_op),
        .req_addr_i    (req_addr),
        .req_wdata_i   (req_wdata),
        .fill_valid_i  (fill_valid),
        .fill_addr_i   (fill_addr),
        .fill_way_i    (fill_way),
        .st_valid_i    (st_valid),
        .st_addr_i     (st_addr),
        .st_data_i     (st_data),
        .mem_wr_o      (mem_wr),
        .mem_addr_o    (mem_addr),
        .mem_data_o    (mem_data),
        .lookup_addr_i (lookup_addr),
        .lookup_hit_o  (lookup_hit),
        .mshr_empty_i  (mshr_empty),
        .rtab_empty_i  (rtab_empty)
    );

    bind cmo_subsys_top cmo_subsys_chk i_chk (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_i (req_ready_o),
        .mem_wr_i    (mem_wr_o),
        .dir_inval_i (dir_inval)
    );

    task automatic check_val(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // Edge plus drive delay
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic addr_t line_addr(input logic [TAG_WIDTH-1:0] tag, input int set);
        return {tag, SET_WIDTH'(set), OFFSET_WIDTH'(0)};
    endfunction

    function automatic logic model_hit(input addr_t a);
        int   s;
        logic hit;
        s   = int'(a[OFFSET_WIDTH +: SET_WIDTH]);
        hit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == a[ADDR_WIDTH-1 -: TAG_WIDTH]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic void model_clear_line(input addr_t a);
        int s;
        s = int'(a[OFFSET_WIDTH +: SET_WIDTH]);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_tag[s][w] == a[ADDR_WIDTH-1 -: TAG_WIDTH]) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endfunction

    function automatic void model_clear_set(input int s, input logic [NUM_WAYS-1:0] mask);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (mask[w]) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endfunction

    task automatic check_lookup(input addr_t a);
        lookup_addr = a;
        #2;
        check_val(lookup_hit, model_hit(a), $sformatf("lookup of %0h", a));
        next_cycle();
    endtask

    // Every directory entry against the model
    task automatic verify_dir();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                check_lookup(line_addr(ref_tag[s][w], s));
            end
        end
    endtask

    task automatic fill_line(input int s, input int w, input logic [TAG_WIDTH-1:0] tag);
        fill_valid = 1'b1;
        fill_addr  = line_addr(tag, s);
        fill_way   = WAY_WIDTH'(w);
        next_cycle();
        fill_valid = 1'b0;
        ref_valid[s][w] = 1'b1;
        ref_tag[s][w]   = tag;
    endtask

    task automatic push_stores(input int n);
        for (int i = 0; i < n; i++) begin
            st_valid = 1'b1;
            st_addr  = $urandom;
            st_data  = $urandom;
            exp_addr_q.push_back(st_addr);
            exp_data_q.push_back(st_data);
            next_cycle();
        end
        st_valid = 1'b0;
    endtask

    task automatic send_req(input cmo_op_e op, input addr_t addr, input word_t wdata);
        check_val(req_ready, 1'b1, "ready before request");
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        next_cycle();
        req_valid = 1'b0;
    endtask

    // Cycles from the accepting edge until ready is seen again
    task automatic wait_ready(output int cycles);
        cycles = 1;
        while (!req_ready && cycles <= READY_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!req_ready) begin
            errors++;
            $display("Error at %0t ns: request port not ready again within %0d cycles",
                     $time, READY_TIMEOUT);
        end
    endtask

    task automatic run_op(input cmo_op_e op, input addr_t addr, input word_t wdata,
                          input int exp_cycles);
        int lat;
        send_req(op, addr, wdata);
        wait_ready(lat);
        check_val(lat, exp_cycles, $sformatf("%s ready latency", op.name()));
    endtask

    task automatic test_fill_lookup();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                fill_line(s, w, TAG_WIDTH'($urandom));
            end
        end
        // Refill a few random entries with fresh tags
        repeat (6) begin
            fill_line($urandom % NUM_SETS, $urandom % NUM_WAYS, TAG_WIDTH'($urandom));
        end
        verify_dir();
        repeat (8) begin
            check_lookup(line_addr(TAG_WIDTH'($urandom), $urandom % NUM_SETS));
        end
    endtask

    task automatic test_inval_line();
        addr_t a;
        a = line_addr(ref_tag[3][1], 3);
        run_op(CMO_INVAL_NLINE, a, '0, 3);
        model_clear_line(a);
        verify_dir();
        // Tag not present in set 6
        a = line_addr(~ref_tag[6][2], 6);
        run_op(CMO_INVAL_NLINE, a, '0, 3);
        model_clear_line(a);
        verify_dir();
    endtask

    task automatic test_inval_set();
        run_op(CMO_INVAL_SET, line_addr('0, 5), 32'h0000_000a, 2);
        model_clear_set(5, 4'b1010);
        verify_dir();
    endtask

    task automatic test_inval_all();
        int lat;
        run_op(CMO_INVAL_ALL, '0, '0, NUM_SETS + 1);
        for (int s = 0; s < NUM_SETS; s++) begin
            model_clear_set(s, '1);
        end
        verify_dir();
        for (int s = 0; s < NUM_SETS; s++) begin
            fill_line(s, $urandom % NUM_WAYS, TAG_WIDTH'($urandom));
        end
        // Lines survive while the miss unit is busy
        mshr_empty = 1'b0;
        send_req(CMO_INVAL_ALL, '0, '0);
        verify_dir();
        check_val(req_ready, 1'b0, "ready while miss unit busy");
        mshr_empty = 1'b1;
        wait_ready(lat);
        // One more wait cycle, then one invalidate per set
        check_val(lat, NUM_SETS + 2, "INVAL_ALL ready latency after miss unit idle");
        for (int s = 0; s < NUM_SETS; s++) begin
            model_clear_set(s, '1);
        end
        verify_dir();
    endtask

    task automatic test_store_drain();
        int start;
        int lat;
        start = mem_cnt;
        push_stores(WBUF_DEPTH + 2);
        check_val(mem_cnt - start, 2, "writes forced out by a full buffer");
        send_req(CMO_FENCE, '0, '0);
        wait_ready(lat);
        check_val(exp_addr_q.size(), 0, "stores left after fence");
        check_val(mem_cnt - start, WBUF_DEPTH + 2, "memory writes after fence");
    endtask

    task automatic test_fence_rtab_busy();
        int start;
        int lat;
        start = mem_cnt;
        push_stores(3);
        rtab_empty = 1'b0;
        send_req(CMO_FENCE, '0, '0);
        repeat (10) begin
            check_val(req_ready, 1'b0, "ready during fence with busy replay table");
            next_cycle();
        end
        check_val(mem_cnt - start, 0, "memory writes while replay table busy");
        rtab_empty = 1'b1;
        wait_ready(lat);
        check_val(exp_addr_q.size(), 0, "stores left after fence");
        check_val(mem_cnt - start, 3, "memory writes after fence");
    endtask

    // Memory writes against the expected store order
    always @(negedge clk_i) begin
        if (rst_ni && mem_wr) begin
            mem_cnt++;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: memory write with no store outstanding", $time);
            end else begin
                check_val(mem_addr, exp_addr_q.pop_front(), "memory write address");
                check_val(mem_data, exp_data_q.pop_front(), "memory write data");
            end
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("Error: watchdog expired at %0t ns before the tests finished", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int seed_val;
        seed_val    = $urandom(32'h2b77d898);
        errors      = 0;
        checks      = 0;
        mem_cnt     = 0;
        rst_ni      = 1'b0;
        req_valid   = 1'b0;
        req_op      = CMO_FENCE;
        req_addr    = '0;
        req_wdata   = '0;
        fill_valid  = 1'b0;
        fill_addr   = '0;
        fill_way    = '0;
        st_valid    = 1'b0;
        st_addr     = '0;
        st_data     = '0;
        lookup_addr = '0;
        mshr_empty  = 1'b1;
        rtab_empty  = 1'b1;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_val(req_ready, 1'b1, "ready after reset");
        check_val(mem_wr, 1'b0, "memory write after reset");
        verify_dir();

        test_fill_lookup();
        test_inval_line();
        test_inval_set();
        test_inval_all();
        test_store_drain();
        test_fence_rtab_busy();
        next_cycle();

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dut.i_chk.fail_cnt);
        if (errors == 0 && i_dut.i_chk.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/cache_cfg_pkg.sv
rtl/cmo_pkg.sv
rtl/cache_dir.sv
rtl/write_buffer.sv
rtl/cmo_handler.sv
rtl/cmo_subsys_top.sv
bench/cmo_subsys_chk.sv
bench/tb_cmo_subsys.sv
